// File: files.f
hdl/nvme_host_pkg.sv
hdl/rq_arbiter.sv
hdl/configurator.sv
hdl/doorbell.sv
hdl/host_controller.sv
hdl/cfg_mgmt_rmw.sv
hdl/oculink_port.sv
tests/oculink_port_sva.sv
tests/tb_oculink_port.sv

// File: hdl/cfg_mgmt_rmw.sv
`default_nettype none

module cfg_mgmt_rmw (
  input  logic                         user_clk,
  input  logic                         user_reset,
  output nvme_host_pkg::cfg_mgmt_req_t cfg_mgmt,
  input  nvme_host_pkg::cfg_data_t     read_data,
  input  logic                         done
);

  localparam nvme_host_pkg::cfg_data_t SET_MASK =
    nvme_host_pkg::cfg_data_t'(1) << nvme_host_pkg::LINK_CTRL_BIT;

  typedef enum logic [1:0] {
    READ,
    WRITE,
    IDLE
  } state_e;

  state_e state;

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state    <= READ;
      cfg_mgmt <= '0;
    end else begin
      case (state)
        READ: begin
          if (done) begin
            cfg_mgmt.write_data <= read_data | SET_MASK;  // Keep the other bits
            cfg_mgmt.write      <= 1'b1;
            cfg_mgmt.read       <= 1'b0;
            state               <= WRITE;
          end else begin
            cfg_mgmt.addr        <= nvme_host_pkg::LINK_CTRL_ADDR[9:0];  // Port takes 10 bits
            cfg_mgmt.byte_enable <= 4'hF;
            cfg_mgmt.read        <= 1'b1;
          end
        end
        WRITE: begin
          if (done) begin
            cfg_mgmt <= '0;
            state    <= IDLE;
          end
        end
        default: cfg_mgmt <= '0;  // One shot only
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/configurator.sv
`default_nettype none

module configurator #(
  parameter int CPL_TIMEOUT = 64
) (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  logic                    start_config,
  output logic                    cfg_done,
  output logic                    cfg_error,
  output nvme_host_pkg::axis_rq_t rq,
  input  logic                    rq_ready,
  input  nvme_host_pkg::axis_rc_t rc,
  output logic                    rc_ready
);

  localparam int IDX_W   = $clog2(nvme_host_pkg::CFG_ROM_DEPTH);
  localparam int TIMER_W = $clog2(CPL_TIMEOUT + 1);
  localparam logic [IDX_W-1:0]   LAST_IDX  = IDX_W'(nvme_host_pkg::CFG_ROM_DEPTH - 1);
  localparam logic [TIMER_W-1:0] TIMER_END = TIMER_W'(CPL_TIMEOUT - 1);
  localparam logic [15:0]        DEV_ID    = 16'h0100;  // Bus 1, device 0, function 0

  typedef enum logic [2:0] {
    IDLE,
    SEND_DESC,
    SEND_DATA,
    WAIT_CPL,
    DONE,
    FAIL
  } state_e;

  state_e                     state;
  logic [IDX_W-1:0]           rom_idx;
  logic [TIMER_W-1:0]         cpl_timer;
  nvme_host_pkg::cfg_entry_t  entry;
  nvme_host_pkg::tag_t        req_tag;
  nvme_host_pkg::tag_t        rc_tag;
  nvme_host_pkg::cpl_status_t rc_status;
  logic                       cpl_good;

  assign entry   = nvme_host_pkg::cfg_rom[rom_idx];
  assign req_tag = nvme_host_pkg::tag_t'(rom_idx);  // Tag is the table index

  assign rc_tag    = rc.tdata[nvme_host_pkg::RC_TAG_MSB:nvme_host_pkg::RC_TAG_LSB];
  assign rc_status = rc.tdata[nvme_host_pkg::RC_STATUS_MSB:nvme_host_pkg::RC_STATUS_LSB];
  assign cpl_good  = (rc_tag == req_tag) && (rc_status == '0);

  // ------------------------------------------------------------
  // Table walk
  // ------------------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state     <= IDLE;
      rom_idx   <= '0;
      cpl_timer <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_config) begin
            state   <= SEND_DESC;
            rom_idx <= '0;
          end
        end
        SEND_DESC: begin
          if (rq_ready) state <= SEND_DATA;
        end
        SEND_DATA: begin
          if (rq_ready) begin
            state     <= WAIT_CPL;
            cpl_timer <= '0;
          end
        end
        WAIT_CPL: begin
          if (rc.tvalid) begin
            if (!cpl_good) begin
              state <= FAIL;  // Bad status or stray tag
            end else if (rom_idx == LAST_IDX) begin
              state <= DONE;
            end else begin
              rom_idx <= rom_idx + 1'b1;
              state   <= SEND_DESC;
            end
          end else if (cpl_timer == TIMER_END) begin
            state <= FAIL;
          end else begin
            cpl_timer <= cpl_timer + 1'b1;
          end
        end
        DONE:    state <= IDLE;
        default: state <= FAIL;  // Stuck until reset
      endcase
    end
  end

  // ------------------------------------------------------------
  // Request beats, decoded from state
  // ------------------------------------------------------------
  always_comb begin
    rq = '0;
    case (state)
      SEND_DESC: rq = nvme_host_pkg::desc_beat(nvme_host_pkg::CFG_WR_T0,
                                               nvme_host_pkg::pcie_addr_t'({entry.reg_num, 2'b00}),
                                               req_tag, DEV_ID);
      SEND_DATA: rq = nvme_host_pkg::data_beat(entry.data);
      default:   rq = '0;
    endcase
  end

  assign rc_ready  = (state == WAIT_CPL);
  assign cfg_done  = (state == DONE);
  assign cfg_error = (state == FAIL);

endmodule

`default_nettype wire

// File: hdl/doorbell.sv
`default_nettype none

module doorbell (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  logic                    write_db,
  input  nvme_host_pkg::db_req_t  db_req,
  output logic                    db_done,
  output nvme_host_pkg::axis_rq_t rq,
  input  logic                    rq_ready
);

  typedef enum logic [1:0] {
    DB_IDLE,
    DB_DESC,
    DB_DATA
  } state_e;

  state_e                 state;
  nvme_host_pkg::db_req_t req_q;  // Held for both beats

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state <= DB_IDLE;
    end else begin
      case (state)
        DB_IDLE: begin
          if (write_db) state <= DB_DESC;
        end
        DB_DESC: begin
          if (rq_ready) state <= DB_DATA;
        end
        DB_DATA: begin
          if (rq_ready) state <= DB_IDLE;
        end
        default: state <= DB_IDLE;
      endcase
    end
  end

  always_ff @(posedge user_clk) begin
    if (write_db && (state == DB_IDLE)) begin
      req_q <= db_req;
    end
  end

  // Posted write, one dword, tag unused
  always_comb begin
    case (state)
      DB_DESC: rq = nvme_host_pkg::desc_beat(nvme_host_pkg::MEM_WR, req_q.addr, '0, '0);
      DB_DATA: rq = nvme_host_pkg::data_beat(req_q.value);
      default: rq = '0;
    endcase
  end

  assign db_done = (state == DB_DATA) && rq_ready;  // Value beat accepted

endmodule

`default_nettype wire

// File: hdl/host_controller.sv
`default_nettype none

module host_controller (
  input  logic                   user_clk,
  input  logic                   user_reset,
  input  logic                   link_up,
  output logic                   start_config,
  input  logic                   cfg_done,
  input  logic                   cfg_error,
  output logic                   config_ok,
  output logic                   db_busy,
  input  logic                   sq_tail_wr,
  input  logic                   cq_head_wr,
  input  logic [15:0]            sq_tail,
  input  logic [15:0]            cq_head,
  output logic                   write_db,
  output nvme_host_pkg::db_req_t db_req,
  input  logic                   db_done
);

  typedef enum logic [2:0] {
    WAIT_LINK,
    CONFIG,
    READY,
    RING,
    FAULT
  } state_e;

  state_e state;
  logic   ring_sq;
  logic   ring_cq;

  // SQ tail wins when both strobes arrive together
  assign ring_sq = (state == READY) && sq_tail_wr;
  assign ring_cq = (state == READY) && cq_head_wr && !sq_tail_wr;

  assign start_config = (state == WAIT_LINK) && link_up;
  assign config_ok    = (state == READY) || (state == RING);
  assign db_busy      = (state == RING);

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state    <= WAIT_LINK;
      write_db <= 1'b0;
    end else begin
      write_db <= ring_sq || ring_cq;
      case (state)
        WAIT_LINK: begin
          if (link_up) state <= CONFIG;
        end
        CONFIG: begin
          if (cfg_error) begin
            state <= FAULT;
          end else if (cfg_done) begin
            state <= READY;
          end
        end
        READY: begin
          if (ring_sq || ring_cq) state <= RING;
        end
        RING: begin
          if (db_done) state <= READY;
        end
        default: state <= FAULT;  // Needs a reset to retry
      endcase
    end
  end

  // ------------------------------------------------------------
  // Doorbell request for queue 0
  // ------------------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (ring_sq) begin
      db_req.addr  <= nvme_host_pkg::BAR0_BASE + nvme_host_pkg::SQ0_TDBL_OFFSET;
      db_req.value <= nvme_host_pkg::cfg_data_t'(sq_tail);
    end else if (ring_cq) begin
      db_req.addr  <= nvme_host_pkg::BAR0_BASE + nvme_host_pkg::CQ0_HDBL_OFFSET;
      db_req.value <= nvme_host_pkg::cfg_data_t'(cq_head);
    end
  end

endmodule

`default_nettype wire

// File: hdl/nvme_host_pkg.sv
`default_nettype none

package nvme_host_pkg;

  // ------------------------------------------------------------
  // Stream and field widths
  // ------------------------------------------------------------
  typedef logic [127:0] tdata_t;
  typedef logic [3:0]   tkeep_t;       // One bit per dword
  typedef logic [63:0]  pcie_addr_t;
  typedef logic [7:0]   tag_t;
  typedef logic [31:0]  cfg_data_t;
  typedef logic [9:0]   cfg_reg_t;     // Dword register number
  typedef logic [2:0]   cpl_status_t;  // 0 is successful completion

  // Core request type encodings
  typedef enum logic [3:0] {
    MEM_WR    = 4'b0001,
    CFG_WR_T0 = 4'b1010
  } req_type_e;

  typedef struct packed {
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;
    logic   tvalid;
  } axis_rq_t;

  typedef axis_rq_t axis_rc_t;  // Completions share the beat layout

  typedef struct packed {
    cfg_reg_t  reg_num;
    cfg_data_t data;
  } cfg_entry_t;

  typedef struct packed {
    pcie_addr_t addr;
    cfg_data_t  value;
  } db_req_t;

  typedef struct packed {
    logic [9:0] addr;
    cfg_data_t  write_data;
    logic [3:0] byte_enable;
    logic       write;
    logic       read;
  } cfg_mgmt_req_t;

  // ------------------------------------------------------------
  // Descriptor and completion field positions
  // ------------------------------------------------------------
  localparam int DESC_ADDR_LSB  = 0;
  localparam int DESC_ADDR_MSB  = 63;
  localparam int DESC_DWCNT_LSB = 64;
  localparam int DESC_DWCNT_MSB = 74;
  localparam int DESC_TYPE_LSB  = 75;
  localparam int DESC_TYPE_MSB  = 78;
  localparam int DESC_TAG_LSB   = 96;
  localparam int DESC_TAG_MSB   = 103;
  localparam int DESC_CPLID_LSB = 104;  // Bus, device, function of target
  localparam int DESC_CPLID_MSB = 119;
  localparam int RC_STATUS_LSB  = 43;
  localparam int RC_STATUS_MSB  = 45;
  localparam int RC_TAG_LSB     = 64;
  localparam int RC_TAG_MSB     = 71;

  // ------------------------------------------------------------
  // Address map and bring-up table
  // ------------------------------------------------------------
  localparam pcie_addr_t  BAR0_BASE       = 64'h0000_0010_C000_0000;
  localparam pcie_addr_t  SQ0_TDBL_OFFSET = 64'h0000_0000_0000_1000;
  localparam pcie_addr_t  CQ0_HDBL_OFFSET = 64'h0000_0000_0000_1004;
  localparam logic [19:0] LINK_CTRL_ADDR  = 20'h40082;
  localparam int          LINK_CTRL_BIT   = 27;

  localparam int CFG_ROM_DEPTH = 4;

  localparam cfg_entry_t cfg_rom [CFG_ROM_DEPTH] = '{
    '{reg_num: 10'h006, data: 32'h0001_0100},      // Secondary and subordinate bus 1
    '{reg_num: 10'h004, data: BAR0_BASE[31:0]},
    '{reg_num: 10'h005, data: BAR0_BASE[63:32]},
    '{reg_num: 10'h001, data: 32'h0000_0006}       // Memory space, bus master
  };

  // Descriptor beat, always one dword of payload
  function automatic axis_rq_t desc_beat(req_type_e req_type, pcie_addr_t addr, tag_t tag,
                                         logic [15:0] cpl_id);
    axis_rq_t beat;
    beat = '0;
    beat.tdata[DESC_ADDR_MSB:DESC_ADDR_LSB]   = addr;
    beat.tdata[DESC_DWCNT_MSB:DESC_DWCNT_LSB] = 11'd1;
    beat.tdata[DESC_TYPE_MSB:DESC_TYPE_LSB]   = req_type;
    beat.tdata[DESC_TAG_MSB:DESC_TAG_LSB]     = tag;
    beat.tdata[DESC_CPLID_MSB:DESC_CPLID_LSB] = cpl_id;
    beat.tkeep  = '1;
    beat.tvalid = 1'b1;
    return beat;
  endfunction

  // Closing payload beat
  function automatic axis_rq_t data_beat(cfg_data_t value);
    axis_rq_t beat;
    beat        = '0;
    beat.tdata  = tdata_t'(value);
    beat.tkeep  = 4'b0001;
    beat.tlast  = 1'b1;
    beat.tvalid = 1'b1;
    return beat;
  endfunction

endpackage

`default_nettype wire

// File: hdl/oculink_port.sv
`default_nettype none

module oculink_port #(
  parameter int CPL_TIMEOUT = 64
) (
  input  logic                         user_clk,
  input  logic                         user_reset,
  input  logic                         link_up,
  output nvme_host_pkg::axis_rq_t      rq,
  input  logic                         rq_ready,
  input  nvme_host_pkg::axis_rc_t      rc,
  output logic                         rc_ready,
  input  logic                         sq_tail_wr,
  input  logic                         cq_head_wr,
  input  logic [15:0]                  sq_tail,
  input  logic [15:0]                  cq_head,
  output logic                         config_ok,
  output logic                         cfg_error,
  output logic                         db_busy,
  output nvme_host_pkg::cfg_mgmt_req_t cfg_mgmt,
  input  nvme_host_pkg::cfg_data_t     cfg_mgmt_read_data,
  input  logic                         cfg_mgmt_done
);

  // ------------------------------------------------------------
  // Request sources to the arbiter
  // ------------------------------------------------------------
  nvme_host_pkg::axis_rq_t cfg_rq;
  logic                    cfg_rq_ready;
  nvme_host_pkg::axis_rq_t db_rq;
  logic                    db_rq_ready;
  nvme_host_pkg::axis_rc_t cfg_rc;
  logic                    cfg_rc_ready;

  // Controller handshakes
  logic                   start_config;
  logic                   cfg_done;
  logic                   write_db;
  nvme_host_pkg::db_req_t db_req;
  logic                   db_done;

  rq_arbiter u_rq_arbiter (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .cfg_rq       (cfg_rq),
    .cfg_rq_ready (cfg_rq_ready),
    .db_rq        (db_rq),
    .db_rq_ready  (db_rq_ready),
    .rq           (rq),
    .rq_ready     (rq_ready),
    .rc           (rc),
    .rc_ready     (rc_ready),
    .cfg_rc       (cfg_rc),
    .cfg_rc_ready (cfg_rc_ready)
  );

  configurator #(
    .CPL_TIMEOUT (CPL_TIMEOUT)
  ) u_configurator (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .start_config (start_config),
    .cfg_done     (cfg_done),
    .cfg_error    (cfg_error),
    .rq           (cfg_rq),
    .rq_ready     (cfg_rq_ready),
    .rc           (cfg_rc),
    .rc_ready     (cfg_rc_ready)
  );

  doorbell u_doorbell (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .write_db   (write_db),
    .db_req     (db_req),
    .db_done    (db_done),
    .rq         (db_rq),
    .rq_ready   (db_rq_ready)
  );

  host_controller u_host_controller (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .link_up      (link_up),
    .start_config (start_config),
    .cfg_done     (cfg_done),
    .cfg_error    (cfg_error),
    .config_ok    (config_ok),
    .db_busy      (db_busy),
    .sq_tail_wr   (sq_tail_wr),
    .cq_head_wr   (cq_head_wr),
    .sq_tail      (sq_tail),
    .cq_head      (cq_head),
    .write_db     (write_db),
    .db_req       (db_req),
    .db_done      (db_done)
  );

  // Link control fixup through the core's management port
  cfg_mgmt_rmw u_cfg_mgmt_rmw (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .cfg_mgmt   (cfg_mgmt),
    .read_data  (cfg_mgmt_read_data),
    .done       (cfg_mgmt_done)
  );

endmodule

`default_nettype wire

// File: hdl/rq_arbiter.sv
`default_nettype none

module rq_arbiter (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  nvme_host_pkg::axis_rq_t cfg_rq,
  output logic                    cfg_rq_ready,
  input  nvme_host_pkg::axis_rq_t db_rq,
  output logic                    db_rq_ready,
  output nvme_host_pkg::axis_rq_t rq,
  input  logic                    rq_ready,
  input  nvme_host_pkg::axis_rc_t rc,
  output logic                    rc_ready,
  output nvme_host_pkg::axis_rc_t cfg_rc,
  input  logic                    cfg_rc_ready
);

  typedef enum logic [1:0] {SRC_NONE, SRC_CFG, SRC_DB} src_e;

  src_e lock_src;  // Owner of the packet in flight
  src_e grant;

  // Fixed priority, configurator first
  always_comb begin
    if (lock_src != SRC_NONE) begin
      grant = lock_src;
    end else if (cfg_rq.tvalid) begin
      grant = SRC_CFG;
    end else if (db_rq.tvalid) begin
      grant = SRC_DB;
    end else begin
      grant = SRC_NONE;
    end
  end

  always_comb begin
    case (grant)
      SRC_CFG: rq = cfg_rq;
      SRC_DB:  rq = db_rq;
      default: rq = '0;
    endcase
  end

  assign cfg_rq_ready = rq_ready && (grant == SRC_CFG);
  assign db_rq_ready  = rq_ready && (grant == SRC_DB);

  // Lock as soon as a beat is shown so a stalled beat never changes source
  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      lock_src <= SRC_NONE;
    end else if (rq.tvalid && rq_ready && rq.tlast) begin
      lock_src <= SRC_NONE;  // Packet complete
    end else if (rq.tvalid) begin
      lock_src <= grant;
    end
  end

  // Only the configurator expects completions
  assign cfg_rc   = rc;
  assign rc_ready = cfg_rc_ready;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the OcuLink port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_oculink_port \
  -f files.f \
  --Mdir obj_dir \
  -o tb_oculink_port

./obj_dir/tb_oculink_port

// File: tests/oculink_port_sva.sv
`default_nettype none

module oculink_port_sva (
  input logic                    user_clk,
  input logic                    user_reset,
  input nvme_host_pkg::axis_rq_t rq,
  input logic                    rq_ready,
  input logic                    config_ok,
  input logic                    cfg_error
);

  logic mid_packet;  // Descriptor accepted, data beat pending

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      mid_packet <= 1'b0;
    end else if (rq.tvalid && rq_ready) begin
      mid_packet <= !rq.tlast;
    end
  end

  // ------------------------------------------------------------
  // Stream rules
  // ------------------------------------------------------------
  rq_stall_hold: assert property (@(posedge user_clk) disable iff (user_reset)
    (rq.tvalid && !rq_ready) |=> $stable(rq))
    else $error("rq changed while stalled");

  ok_error_exclusive: assert property (@(posedge user_clk) disable iff (user_reset)
    !(config_ok && cfg_error))
    else $error("config_ok and cfg_error high together");

  second_beat_last: assert property (@(posedge user_clk) disable iff (user_reset)
    (mid_packet && rq.tvalid) |-> rq.tlast)
    else $error("second rq beat without tlast");

endmodule

bind oculink_port oculink_port_sva u_sva (
  .user_clk   (user_clk),
  .user_reset (user_reset),
  .rq         (rq),
  .rq_ready   (rq_ready),
  .config_ok  (config_ok),
  .cfg_error  (cfg_error)
);

`default_nettype wire

// File: tests/tb_oculink_port.sv
`default_nettype none

module tb_oculink_port;

  localparam int          CPL_TIMEOUT = 64;
  localparam int          NUM_SCEN    = 4;
  localparam int          NUM_RINGS   = 4;
  localparam logic [15:0] TARGET_ID   = {8'd1, 5'd0, 3'd0};  // Bus 1, device 0, function 0

  typedef enum logic {SQ_TAIL, CQ_HEAD} queue_e;

  typedef enum {EV_CFG_ERROR, EV_CONFIG_OK, EV_DB_IDLE, EV_MGMT_READ, EV_MGMT_WRITE} event_e;

  typedef struct {
    string                      name;
    int                         fault_idx;  // -1 for a clean run
    nvme_host_pkg::cpl_status_t bad_status;
    logic                       wrong_tag;
    logic                       withhold;
    logic                       exp_error;
  } scenario_t;

  typedef struct {
    queue_e      kind;
    logic [15:0] value;
  } ring_t;

  // Name, faulty entry, status, wrong tag, no completion, expected cfg_error
  scenario_t scenarios [NUM_SCEN] = '{
    '{"clean",      -1, 3'd0, 1'b0, 1'b0, 1'b0},
    '{"bad_status",  2, 3'd1, 1'b0, 1'b0, 1'b1},  // Unsupported request
    '{"wrong_tag",   2, 3'd0, 1'b1, 1'b0, 1'b1},
    '{"timeout",     1, 3'd0, 1'b0, 1'b1, 1'b1}
  };

  // Queue 0 doorbells for the clean run
  ring_t rings [NUM_RINGS] = '{
    '{SQ_TAIL, 16'h0001},
    '{CQ_HEAD, 16'h0001},
    '{SQ_TAIL, 16'h0002},
    '{CQ_HEAD, 16'hbeef}
  };

  logic                         user_clk;
  logic                         user_reset;
  logic                         link_up;
  nvme_host_pkg::axis_rq_t      rq;
  logic                         rq_ready;
  nvme_host_pkg::axis_rc_t      rc;
  logic                         rc_ready;
  logic                         sq_tail_wr;
  logic                         cq_head_wr;
  logic [15:0]                  sq_tail;
  logic [15:0]                  cq_head;
  logic                         config_ok;
  logic                         cfg_error;
  logic                         db_busy;
  nvme_host_pkg::cfg_mgmt_req_t cfg_mgmt;
  nvme_host_pkg::cfg_data_t     cfg_mgmt_read_data;
  logic                         cfg_mgmt_done;

  nvme_host_pkg::axis_rq_t beats [$];  // Accepted RQ beats, oldest first

  oculink_port #(
    .CPL_TIMEOUT (CPL_TIMEOUT)
  ) DUT (
    .user_clk           (user_clk),
    .user_reset         (user_reset),
    .link_up            (link_up),
    .rq                 (rq),
    .rq_ready           (rq_ready),
    .rc                 (rc),
    .rc_ready           (rc_ready),
    .sq_tail_wr         (sq_tail_wr),
    .cq_head_wr         (cq_head_wr),
    .sq_tail            (sq_tail),
    .cq_head            (cq_head),
    .config_ok          (config_ok),
    .cfg_error          (cfg_error),
    .db_busy            (db_busy),
    .cfg_mgmt           (cfg_mgmt),
    .cfg_mgmt_read_data (cfg_mgmt_read_data),
    .cfg_mgmt_done      (cfg_mgmt_done)
  );

  initial begin
    user_clk = 1'b0;
    forever #5 user_clk = ~user_clk;
  end

  // RQ monitor
  always @(posedge user_clk) begin
    if (!user_reset && rq.tvalid && rq_ready) begin
      beats.push_back(rq);
    end
  end

  // ------------------------------------------------------------
  // Reporting and waiting
  // ------------------------------------------------------------
  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_field(string test, string field, logic [127:0] exp, logic [127:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test, field, exp, act);
      stop_run();
    end
  endtask

  // One cycle, with fresh back-pressure on the falling edge
  task automatic step();
    @(negedge user_clk);
    rq_ready = ($urandom_range(3, 0) != 0);
  endtask

  function automatic logic event_seen(event_e ev);
    case (ev)
      EV_CFG_ERROR: return cfg_error;
      EV_CONFIG_OK: return config_ok;
      EV_DB_IDLE:   return !db_busy;
      EV_MGMT_READ: return cfg_mgmt.read;
      default:      return cfg_mgmt.write;
    endcase
  endfunction

  task automatic wait_event(string test, event_e ev, int limit);
    int n;
    n = 0;
    while (!event_seen(ev)) begin
      step();
      n++;
      if (n > limit) begin
        report_failure($sformatf("%s: waited %0d cycles for %s, it never came",
                                 test, limit, ev.name()));
      end
    end
  endtask

  task automatic wait_beats(string test, int count);
    int n;
    n = 0;
    while (beats.size() < count) begin
      step();
      n++;
      if (n > 50) begin
        report_failure($sformatf("%s: no complete RQ packet within 50 cycles", test));
      end
    end
  endtask

  // ------------------------------------------------------------
  // Packet checks
  // ------------------------------------------------------------
  task automatic check_desc(string test, nvme_host_pkg::axis_rq_t beat, logic [3:0] exp_type,
                            nvme_host_pkg::pcie_addr_t exp_addr, nvme_host_pkg::tag_t exp_tag);
    check_field(test, "address", 128'(exp_addr),
                128'(beat.tdata[nvme_host_pkg::DESC_ADDR_MSB:nvme_host_pkg::DESC_ADDR_LSB]));
    check_field(test, "dword count", 128'(1),
                128'(beat.tdata[nvme_host_pkg::DESC_DWCNT_MSB:nvme_host_pkg::DESC_DWCNT_LSB]));
    check_field(test, "request type", 128'(exp_type),
                128'(beat.tdata[nvme_host_pkg::DESC_TYPE_MSB:nvme_host_pkg::DESC_TYPE_LSB]));
    check_field(test, "tag", 128'(exp_tag),
                128'(beat.tdata[nvme_host_pkg::DESC_TAG_MSB:nvme_host_pkg::DESC_TAG_LSB]));
    check_field(test, "desc tkeep", 128'(4'hf), 128'(beat.tkeep));
    check_field(test, "desc tlast", 128'(1'b0), 128'(beat.tlast));
  endtask

  task automatic check_data(string test, nvme_host_pkg::axis_rq_t beat,
                            nvme_host_pkg::cfg_data_t exp_value);
    check_field(test, "data", 128'(exp_value), beat.tdata);
    check_field(test, "data tkeep", 128'(4'b0001), 128'(beat.tkeep));
    check_field(test, "data tlast", 128'(1'b1), 128'(beat.tlast));
  endtask

  task automatic check_cfg_packet(string test, int idx);
    nvme_host_pkg::axis_rq_t   desc;
    nvme_host_pkg::axis_rq_t   data;
    nvme_host_pkg::cfg_entry_t entry;
    desc  = beats.pop_front();
    data  = beats.pop_front();
    entry = nvme_host_pkg::cfg_rom[idx];
    // Byte address of the dword register
    check_desc(test, desc, nvme_host_pkg::CFG_WR_T0,
               nvme_host_pkg::pcie_addr_t'(entry.reg_num) * 4, nvme_host_pkg::tag_t'(idx));
    check_field(test, "target id", 128'(TARGET_ID),
                128'(desc.tdata[nvme_host_pkg::DESC_CPLID_MSB:nvme_host_pkg::DESC_CPLID_LSB]));
    check_data(test, data, entry.data);
  endtask

  // ------------------------------------------------------------
  // PCIe core model
  // ------------------------------------------------------------
  task automatic send_completion(string test, nvme_host_pkg::tag_t tag,
                                 nvme_host_pkg::cpl_status_t status);
    int n;
    repeat ($urandom_range(4, 0)) step();
    rc = '0;
    rc.tdata[nvme_host_pkg::RC_TAG_MSB:nvme_host_pkg::RC_TAG_LSB]       = tag;
    rc.tdata[nvme_host_pkg::RC_STATUS_MSB:nvme_host_pkg::RC_STATUS_LSB] = status;
    rc.tkeep  = 4'b0111;  // Three-dword header
    rc.tlast  = 1'b1;
    rc.tvalid = 1'b1;
    n = 0;
    while (!rc_ready) begin
      step();
      n++;
      if (n > 8) report_failure($sformatf("%s: completion never accepted", test));
    end
    step();
    rc = '0;
  endtask

  task automatic apply_reset(string test);
    user_reset    = 1'b1;
    link_up       = 1'b0;
    rc            = '0;
    sq_tail_wr    = 1'b0;
    cq_head_wr    = 1'b0;
    cfg_mgmt_done = 1'b0;
    repeat (8) step();
    user_reset = 1'b0;
    beats.delete();
    check_field(test, "rq tvalid", 128'(1'b0), 128'(rq.tvalid));
    check_field(test, "rc_ready", 128'(1'b0), 128'(rc_ready));
    check_field(test, "start_config", 128'(1'b0), 128'(DUT.start_config));
    check_field(test, "cfg_done", 128'(1'b0), 128'(DUT.cfg_done));
    check_field(test, "config_ok", 128'(1'b0), 128'(config_ok));
    check_field(test, "cfg_error", 128'(1'b0), 128'(cfg_error));
    check_field(test, "db_busy", 128'(1'b0), 128'(db_busy));
    check_field(test, "mgmt read", 128'(1'b0), 128'(cfg_mgmt.read));
    check_field(test, "mgmt write", 128'(1'b0), 128'(cfg_mgmt.write));
  endtask

  // Link control read, answered with random data, then the write back
  task automatic run_link_ctrl(string test);
    nvme_host_pkg::cfg_data_t rd;
    wait_event(test, EV_MGMT_READ, 8);
    check_field(test, "mgmt addr", 128'(nvme_host_pkg::LINK_CTRL_ADDR[9:0]), 128'(cfg_mgmt.addr));
    check_field(test, "mgmt write", 128'(1'b0), 128'(cfg_mgmt.write));
    repeat ($urandom_range(3, 0)) step();
    rd                 = $urandom();
    cfg_mgmt_read_data = rd;
    cfg_mgmt_done      = 1'b1;
    step();
    cfg_mgmt_done = 1'b0;
    wait_event(test, EV_MGMT_WRITE, 8);
    check_field(test, "mgmt write addr", 128'(nvme_host_pkg::LINK_CTRL_ADDR[9:0]),
                128'(cfg_mgmt.addr));
    check_field(test, "mgmt write data", 128'(rd | (32'h1 << nvme_host_pkg::LINK_CTRL_BIT)),
                128'(cfg_mgmt.write_data));
    check_field(test, "mgmt byte enable", 128'(4'hf), 128'(cfg_mgmt.byte_enable));
    check_field(test, "mgmt read", 128'(1'b0), 128'(cfg_mgmt.read));
    repeat ($urandom_range(3, 0)) step();
    cfg_mgmt_done = 1'b1;
    step();
    cfg_mgmt_done = 1'b0;
    check_field(test, "mgmt read after done", 128'(1'b0), 128'(cfg_mgmt.read));
    check_field(test, "mgmt write after done", 128'(1'b0), 128'(cfg_mgmt.write));
  endtask

  task automatic strobe_gated(string test);
    sq_tail_wr = 1'b1;
    sq_tail    = 16'h0055;
    cq_head_wr = 1'b1;
    cq_head    = 16'h00aa;
    step();
    sq_tail_wr = 1'b0;
    cq_head_wr = 1'b0;
    repeat (10) step();
    check_field(test, "beats while config_ok low", 128'(0), 128'(beats.size()));
    check_field(test, "db_busy", 128'(1'b0), 128'(db_busy));
  endtask

  task automatic run_config(scenario_t sc);
    nvme_host_pkg::tag_t tag;
    for (int idx = 0; idx < nvme_host_pkg::CFG_ROM_DEPTH; idx++) begin
      wait_beats(sc.name, 2);
      check_cfg_packet(sc.name, idx);
      tag = nvme_host_pkg::tag_t'(idx);
      if (idx != sc.fault_idx) begin
        send_completion(sc.name, tag, 3'd0);
      end else begin
        if (!sc.withhold) begin
          send_completion(sc.name, sc.wrong_tag ? tag + 8'd5 : tag, sc.bad_status);
        end
        wait_event(sc.name, EV_CFG_ERROR, sc.withhold ? CPL_TIMEOUT + 8 : 8);
        break;
      end
    end
    if (sc.exp_error) begin
      strobe_gated(sc.name);  // Fault state ignores doorbells
    end else begin
      wait_event(sc.name, EV_CONFIG_OK, 8);
    end
    repeat (20) step();
    check_field(sc.name, "extra RQ beats", 128'(0), 128'(beats.size()));
    check_field(sc.name, "cfg_error", 128'(sc.exp_error), 128'(cfg_error));
    check_field(sc.name, "config_ok", 128'(!sc.exp_error), 128'(config_ok));
  endtask

  task automatic ring_doorbells(string test);
    nvme_host_pkg::pcie_addr_t exp_addr;
    string                     row;
    foreach (rings[r]) begin
      row = $sformatf("%s_db%0d", test, r);
      if (rings[r].kind == SQ_TAIL) begin
        sq_tail_wr = 1'b1;
        sq_tail    = rings[r].value;
        exp_addr   = nvme_host_pkg::BAR0_BASE + nvme_host_pkg::SQ0_TDBL_OFFSET;
      end else begin
        cq_head_wr = 1'b1;
        cq_head    = rings[r].value;
        exp_addr   = nvme_host_pkg::BAR0_BASE + nvme_host_pkg::CQ0_HDBL_OFFSET;
      end
      step();
      sq_tail_wr = 1'b0;
      cq_head_wr = 1'b0;
      check_field(row, "db_busy after strobe", 128'(1'b1), 128'(db_busy));
      wait_beats(row, 2);
      check_desc(row, beats.pop_front(), nvme_host_pkg::MEM_WR, exp_addr, 8'd0);
      check_data(row, beats.pop_front(), 32'(rings[r].value));
      wait_event(row, EV_DB_IDLE, 8);
      repeat (4) step();  // Room for a stray second packet
      check_field(row, "extra RQ beats", 128'(0), 128'(beats.size()));
    end
  endtask

  // ------------------------------------------------------------
  // Scenario loop
  // ------------------------------------------------------------
  initial begin
    user_reset         = 1'b1;
    link_up            = 1'b0;
    rq_ready           = 1'b0;
    rc                 = '0;
    sq_tail_wr         = 1'b0;
    cq_head_wr         = 1'b0;
    sq_tail            = '0;
    cq_head            = '0;
    cfg_mgmt_read_data = '0;
    cfg_mgmt_done      = 1'b0;
    void'($urandom(32'hd767_abe4));

    foreach (scenarios[s]) begin
      apply_reset(scenarios[s].name);
      run_link_ctrl(scenarios[s].name);
      strobe_gated(scenarios[s].name);
      link_up = 1'b1;
      run_config(scenarios[s]);
      if (!scenarios[s].exp_error) begin
        ring_doorbells(scenarios[s].name);
      end
      check_field(scenarios[s].name, "mgmt read at end", 128'(1'b0), 128'(cfg_mgmt.read));
      check_field(scenarios[s].name, "mgmt write at end", 128'(1'b0), 128'(cfg_mgmt.write));
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
